/* sources.f */
src/dft_pkg.sv
src/dft_rdx4_core.sv
src/dft_sink.sv
src/dft_source.sv
src/dft_stage_engine.sv
src/dft_mem_top.sv
sim/tb_dft.sv

/* run_sim.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -Wno-fatal -f sources.f --top-module tb_dft -Mdir obj_dir -o tb_dft \
	&& ./obj_dir/tb_dft | tee sim.log \
	|| { echo "build or run failed"; exit 1; }
grep -q "^TESTS PASSED$" sim.log && echo "simulation passed" && exit 0 \
	|| { echo "simulation failed"; exit 1; }

/* sim/tb_dft.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_dft import dft_pkg::*; ();

	localparam int FRAMES_B2B = 20;
	localparam int FRAMES_CREDIT = 8;
	localparam int FRAMES_JUNK = 6;
	// single frame, three special frames
	localparam int NUM_FRAMES = 1 + FRAMES_B2B + FRAMES_CREDIT + FRAMES_JUNK + 3;
	// input, two passes and output of one frame
	localparam int FRAME_NS = 2000;
	localparam int MARGIN_NS = 60000;
	// (-j)^r as a unit complex value
	localparam int ROT_RE [RADIX] = '{1, 0, -1, 0};
	localparam int ROT_IM [RADIX] = '{0, -1, 0, 1};

	logic clk;
	logic rst_n;
	logic in_sop;
	logic in_valid;
	sample_t in_re;
	sample_t in_im;
	logic sink_ready;
	logic out_credit;
	logic out_valid;
	logic out_sop;
	logic out_eop;
	sample_t out_re;
	sample_t out_im;

	integer seed;
	int cyc;
	int out_idx;
	// outputs seen and not yet paid back with a credit
	int outstanding;
	int sample_errs;
	int flag_errs;
	int other_errs;
	logic gap_junk;
	logic slow_credit;
	string cur_name;
	sample_t frm_re [DFT_POINTS];
	sample_t frm_im [DFT_POINTS];
	sample_t exp_re_q [$];
	sample_t exp_im_q [$];
	string name_q [$];
	// cycle on which each credit goes back
	int due_q [$];

	dft_mem_top u_dft_mem_top (
		.clk (clk),
		.rst_n (rst_n),
		.in_sop (in_sop),
		.in_valid (in_valid),
		.in_re (in_re),
		.in_im (in_im),
		.sink_ready (sink_ready),
		.out_credit (out_credit),
		.out_valid (out_valid),
		.out_sop (out_sop),
		.out_eop (out_eop),
		.out_re (out_re),
		.out_im (out_im)
	);

	always #10 clk = ~clk;

	// --------------------
	// compare tasks
	// --------------------
	task automatic check_sample(input string name, input sample_t exp, input sample_t act);
		if (act !== exp) begin
			sample_errs++;
			$display("ERR %s expected %0d actual %0d", name, exp, act);
		end
	endtask

	task automatic check_flag(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			flag_errs++;
			$display("ERR %s expected %b actual %b", name, exp, act);
		end
	endtask

	// --------------------
	// reference model
	// --------------------
	// two radix-4 passes in place, twiddles after pass 0, digit-reversed readout
	task automatic predict_frame(input string name);
		int w_re [DFT_POINTS];
		int w_im [DFT_POINTS];
		int x_re [RADIX];
		int x_im [RADIX];
		int acc_re;
		int acc_im;
		int t_re;
		int t_im;
		int r;
		int a;
		for (int i = 0; i < DFT_POINTS; i++) begin
			w_re[i] = frm_re[i];
			w_im[i] = frm_im[i];
		end
		for (int p = 0; p < NUM_STAGES; p++) begin
			for (int g = 0; g < RADIX; g++) begin
				// pass 0 strides by 4, pass 1 takes a contiguous quad
				for (int m = 0; m < RADIX; m++) begin
					a = (p == 0) ? g + RADIX * m : RADIX * g + m;
					x_re[m] = w_re[a];
					x_im[m] = w_im[a];
				end
				for (int k = 0; k < RADIX; k++) begin
					acc_re = 0;
					acc_im = 0;
					for (int m = 0; m < RADIX; m++) begin
						r = (k * m) % RADIX;
						acc_re += ROT_RE[r] * x_re[m] - ROT_IM[r] * x_im[m];
						acc_im += ROT_RE[r] * x_im[m] + ROT_IM[r] * x_re[m];
					end
					// fixed 1/4 scale
					acc_re = acc_re >>> 2;
					acc_im = acc_im >>> 2;
					if (p == 0) begin
						// W16^(n*k), then drop the Q14 fraction
						r = (g * k) % DFT_POINTS;
						t_re = acc_re * TWDL_COS[r] - acc_im * TWDL_SIN[r];
						t_im = acc_re * TWDL_SIN[r] + acc_im * TWDL_COS[r];
						acc_re = int'(sample_t'(t_re >>> TWDL_FRAC));
						acc_im = int'(sample_t'(t_im >>> TWDL_FRAC));
					end
					a = (p == 0) ? g + RADIX * k : RADIX * g + k;
					w_re[a] = acc_re;
					w_im[a] = acc_im;
				end
			end
		end
		for (int i = 0; i < DFT_POINTS; i++) begin
			a = RADIX * (i % RADIX) + i / RADIX;
			exp_re_q.push_back(sample_t'(w_re[a]));
			exp_im_q.push_back(sample_t'(w_im[a]));
		end
		name_q.push_back(name);
	endtask

	// --------------------
	// stimulus
	// --------------------
	task automatic load_random_frame();
		for (int i = 0; i < DFT_POINTS; i++) begin
			frm_re[i] = sample_t'($random(seed));
			frm_im[i] = sample_t'($random(seed));
		end
	endtask

	task automatic fill_frame(input sample_t re, input sample_t im);
		for (int i = 0; i < DFT_POINTS; i++) begin
			frm_re[i] = re;
			frm_im[i] = im;
		end
	endtask

	// between frames, either quiet or random valid and sop noise
	task automatic drive_gap();
		if (gap_junk) begin
			in_valid = ($random(seed) & 1) != 0;
			in_sop = ($random(seed) & 1) != 0;
		end else begin
			in_valid = 1'b0;
			in_sop = 1'b0;
		end
		in_re = sample_t'($random(seed));
		in_im = sample_t'($random(seed));
	endtask

	// entered and left 2 ns after a rising edge
	task automatic send_frame(input string name);
		int i;
		predict_frame(name);
		while (!sink_ready) begin
			drive_gap();
			@(posedge clk);
			#2;
		end
		i = 0;
		while (i < DFT_POINTS) begin
			// no gap before sop, random gaps after it
			if (i != 0 && ($random(seed) & 3) == 0) begin
				in_valid = 1'b0;
				in_sop = 1'b0;
			end else begin
				in_valid = 1'b1;
				in_sop = (i == 0);
				in_re = frm_re[i];
				in_im = frm_im[i];
				i++;
			end
			@(posedge clk);
			#2;
		end
		drive_gap();
	endtask

	// --------------------
	// output monitor
	// --------------------
	always @(negedge clk) begin
		if (rst_n) begin
			if (out_valid) begin
				if (exp_re_q.size() == 0) begin
					other_errs++;
					$display("output seen with no frame pending, re %0d im %0d",
						out_re, out_im);
				end else begin
					if (out_idx == 0) begin
						cur_name = name_q.pop_front();
					end
					check_sample($sformatf("%s[%0d].re", cur_name, out_idx),
						exp_re_q.pop_front(), out_re);
					check_sample($sformatf("%s[%0d].im", cur_name, out_idx),
						exp_im_q.pop_front(), out_im);
					check_flag($sformatf("%s[%0d].sop", cur_name, out_idx),
						out_idx == 0, out_sop);
					check_flag($sformatf("%s[%0d].eop", cur_name, out_idx),
						out_idx == DFT_POINTS - 1, out_eop);
					out_idx = (out_idx + 1) % DFT_POINTS;
					outstanding++;
					if (outstanding > OUT_CREDITS) begin
						other_errs++;
						$display("credit overrun, %0d outputs sent without a returned credit",
							outstanding);
					end
					due_q.push_back(cyc + 1 + (slow_credit ? ($random(seed) & 15) : 0));
				end
			end else if (out_sop || out_eop) begin
				other_errs++;
				$display("sop or eop raised without out_valid");
			end
		end
	end

	// credit return, at most one pulse per cycle
	always @(posedge clk) begin
		int hit;
		#2;
		cyc++;
		hit = -1;
		for (int j = 0; j < due_q.size(); j++) begin
			if (hit < 0 && due_q[j] <= cyc) begin
				hit = j;
			end
		end
		if (hit >= 0) begin
			due_q.delete(hit);
			outstanding--;
			out_credit = 1'b1;
		end else begin
			out_credit = 1'b0;
		end
	end

	// watchdog
	initial begin
		#(NUM_FRAMES * FRAME_NS + MARGIN_NS);
		$display("timeout with %0d outputs still expected, errors: %0d value, %0d flag, %0d other",
			exp_re_q.size(), sample_errs, flag_errs, other_errs);
		$display("TESTS FAILED");
		$finish;
	end

	// --------------------
	// test sequence
	// --------------------
	initial begin
		clk = 1'b0;
		rst_n = 1'b0;
		in_sop = 1'b0;
		in_valid = 1'b0;
		in_re = '0;
		in_im = '0;
		out_credit = 1'b0;
		seed = 32'h162f8f8a;
		cyc = 0;
		out_idx = 0;
		outstanding = 0;
		sample_errs = 0;
		flag_errs = 0;
		other_errs = 0;
		gap_junk = 1'b0;
		slow_credit = 1'b0;
		repeat (10) @(posedge clk);
		#2;
		rst_n = 1'b1;

		// quiet output after reset, input opens
		@(negedge clk);
		check_flag("reset out_valid", 1'b0, out_valid);
		for (int n = 0; n < 8 && !sink_ready; n++) @(negedge clk);
		check_flag("reset sink_ready", 1'b1, sink_ready);
		@(posedge clk);
		#2;
		load_random_frame();
		send_frame("single");

		// back to back, prompt credits
		for (int f = 0; f < FRAMES_B2B; f++) begin
			load_random_frame();
			send_frame($sformatf("b2b%0d", f));
		end

		// credits come back 0 to 15 cycles late
		slow_credit = 1'b1;
		for (int f = 0; f < FRAMES_CREDIT; f++) begin
			load_random_frame();
			send_frame($sformatf("credit%0d", f));
		end

		// noise on valid and sop while the input is closed
		gap_junk = 1'b1;
		for (int f = 0; f < FRAMES_JUNK; f++) begin
			load_random_frame();
			send_frame($sformatf("junk%0d", f));
		end
		gap_junk = 1'b0;

		fill_frame('0, '0);
		send_frame("zero");
		fill_frame('0, '0);
		frm_re[0] = 16'sh4000;
		send_frame("impulse");
		fill_frame(16'sh8000, 16'sh8000);
		send_frame("neg_full");
		drive_gap();

		while (exp_re_q.size() != 0) @(posedge clk);
		// stray outputs after the last frame
		repeat (20) @(posedge clk);
		$display("errors: %0d value, %0d flag, %0d other", sample_errs, flag_errs, other_errs);
		if (sample_errs + flag_errs + other_errs == 0) begin
			$display("TESTS PASSED");
		end else begin
			$display("TESTS FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* src/dft_mem_top.sv */
`timescale 1ns/1ps
`default_nettype none

module dft_mem_top import dft_pkg::*; (
	input wire clk,
	input wire rst_n,
	input wire in_sop,
	input wire in_valid,
	input wire sample_t in_re,
	input wire sample_t in_im,
	output logic sink_ready,
	input wire out_credit,
	output logic out_valid,
	output logic out_sop,
	output logic out_eop,
	output sample_t out_re,
	output sample_t out_im
);

	frame_state_t state;
	// passes finished in this frame
	stage_t pass_cnt;
	logic frame_start;
	logic sink_active;

	logic sink_wr_en, eng_wr_en;
	addr_t sink_wr_addr, eng_wr_addr;
	sample_t sink_wr_re, sink_wr_im;
	sample_t eng_wr_re, eng_wr_im;
	logic eng_rd_en, src_rd_en;
	addr_t eng_rd_addr, src_rd_addr;
	logic sink_done, rd_done, wr_done, source_done;

	// frame RAM and its registered ports
	sample_t mem_re [DFT_POINTS];
	sample_t mem_im [DFT_POINTS];
	logic ram_we;
	addr_t ram_waddr;
	sample_t ram_wre, ram_wim;
	logic ram_rd;
	addr_t ram_raddr;
	sample_t ram_qre, ram_qim;

	assign frame_start = (state == IDLE) && sink_ready && in_valid && in_sop;
	// the first sample is taken in the cycle that leaves IDLE
	assign sink_active = ((state == IDLE) && sink_ready) || (state == SINK);

	// --------------------
	// frame FSM
	// --------------------
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= IDLE;
			pass_cnt <= '0;
			sink_ready <= 1'b0;
		end else begin
			sink_ready <= (state == IDLE) && !frame_start;
			case (state)
			IDLE: if (frame_start) state <= SINK;
			SINK: if (sink_done) state <= RD;
			RD: if (rd_done) state <= WAIT_WR;
			WAIT_WR: begin
				if (wr_done) begin
					state <= (pass_cnt == stage_t'(NUM_STAGES - 1)) ? SOURCE : RD;
				end
			end
			SOURCE: if (source_done) state <= IDLE;
			default: state <= IDLE;
			endcase
			if (state == IDLE) begin
				pass_cnt <= '0;
			end else if ((state == WAIT_WR) && wr_done) begin
				pass_cnt <= pass_cnt + 1'b1;
			end
		end
	end

	// --------------------
	// port muxes
	// --------------------
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			ram_we <= 1'b0;
			ram_rd <= 1'b0;
		end else begin
			ram_we <= (state == SINK) ? sink_wr_en : eng_wr_en;
			case (state)
			RD, WAIT_WR: ram_rd <= eng_rd_en;
			SOURCE: ram_rd <= src_rd_en;
			default: ram_rd <= 1'b0;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		ram_waddr <= (state == SINK) ? sink_wr_addr : eng_wr_addr;
		ram_wre <= (state == SINK) ? sink_wr_re : eng_wr_re;
		ram_wim <= (state == SINK) ? sink_wr_im : eng_wr_im;
		ram_raddr <= (state == SOURCE) ? src_rd_addr : eng_rd_addr;
	end

	// one-cycle read latency from the registered address
	always_ff @(posedge clk) begin
		if (ram_we) begin
			mem_re[ram_waddr] <= ram_wre;
			mem_im[ram_waddr] <= ram_wim;
		end
		if (ram_rd) begin
			ram_qre <= mem_re[ram_raddr];
			ram_qim <= mem_im[ram_raddr];
		end
	end

	dft_sink u_sink (
		.clk (clk),
		.rst_n (rst_n),
		.active (sink_active),
		.in_sop (in_sop),
		.in_valid (in_valid),
		.in_re (in_re),
		.in_im (in_im),
		.wr_en (sink_wr_en),
		.wr_addr (sink_wr_addr),
		.wr_re (sink_wr_re),
		.wr_im (sink_wr_im),
		.sink_done (sink_done)
	);

	dft_stage_engine u_engine (
		.clk (clk),
		.rst_n (rst_n),
		.state (state),
		.rd_en (eng_rd_en),
		.rd_addr (eng_rd_addr),
		.rd_re (ram_qre),
		.rd_im (ram_qim),
		.wr_en (eng_wr_en),
		.wr_addr (eng_wr_addr),
		.wr_re (eng_wr_re),
		.wr_im (eng_wr_im),
		.rd_done (rd_done),
		.wr_done (wr_done)
	);

	dft_source u_source (
		.clk (clk),
		.rst_n (rst_n),
		.active (state == SOURCE),
		.out_credit (out_credit),
		.rd_en (src_rd_en),
		.rd_addr (src_rd_addr),
		.rd_re (ram_qre),
		.rd_im (ram_qim),
		.out_valid (out_valid),
		.out_sop (out_sop),
		.out_eop (out_eop),
		.out_re (out_re),
		.out_im (out_im),
		.source_done (source_done)
	);

endmodule

`default_nettype wire

/* src/dft_stage_engine.sv */
`timescale 1ns/1ps
`default_nettype none

module dft_stage_engine import dft_pkg::*; (
	input wire clk,
	input wire rst_n,
	input wire frame_state_t state,
	output logic rd_en,
	output addr_t rd_addr,
	input wire sample_t rd_re,
	input wire sample_t rd_im,
	output logic wr_en,
	output addr_t wr_addr,
	output sample_t wr_re,
	output sample_t wr_im,
	output logic rd_done,
	output logic wr_done
);

	stage_t pass;
	addr_t rd_cnt;
	logic rd_fin;
	// top register plus RAM register
	logic [1:0] rd_vld_d;
	addr_t gat_cnt;
	sample_t op_re [RADIX];
	sample_t op_im [RADIX];
	logic core_in_valid;
	addr_t core_step;
	logic [1:0] grp_q;
	logic [1:0] grp_pipe [CORE_LATENCY];
	logic core_out_valid;
	sample_t cr_re [RADIX];
	sample_t cr_im [RADIX];
	sample_t wb_re [RADIX];
	sample_t wb_im [RADIX];
	logic [1:0] wb_grp;
	logic [1:0] wb_k;
	logic wb_busy;
	addr_t wr_cnt;

	// pass 0 walks n + 4k, pass 1 walks 4m + k
	// reads and write-backs share the same map, so the passes stay in place
	function automatic addr_t map_addr(input stage_t p, input logic [1:0] grp,
			input logic [1:0] elem);
		return (p == '0) ? {elem, grp} : {grp, elem};
	endfunction

	// --------------------
	// read side
	// --------------------
	assign rd_en = (state == RD) && !rd_fin;
	assign rd_addr = map_addr(pass, rd_cnt[3:2], rd_cnt[1:0]);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			rd_cnt <= '0;
			rd_fin <= 1'b0;
			rd_done <= 1'b0;
			pass <= '0;
		end else begin
			rd_done <= rd_en && (rd_cnt == addr_t'(DFT_POINTS - 1));
			if (rd_en) begin
				rd_cnt <= rd_cnt + 1'b1;
				if (rd_cnt == addr_t'(DFT_POINTS - 1)) begin
					rd_fin <= 1'b1;
				end
			end else if (state != RD) begin
				rd_fin <= 1'b0;
			end
			// next pass once this one is fully written back
			if (state == IDLE) begin
				pass <= '0;
			end else if (wr_done) begin
				pass <= pass + 1'b1;
			end
		end
	end

	// gather four returning words into one group
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			rd_vld_d <= '0;
			gat_cnt <= '0;
			core_in_valid <= 1'b0;
		end else begin
			rd_vld_d <= {rd_vld_d[0], rd_en};
			core_in_valid <= rd_vld_d[1] && (gat_cnt[1:0] == 2'd3);
			if (rd_vld_d[1]) begin
				gat_cnt <= gat_cnt + 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rd_vld_d[1]) begin
			op_re[gat_cnt[1:0]] <= rd_re;
			op_im[gat_cnt[1:0]] <= rd_im;
			grp_q <= gat_cnt[3:2];
			// twiddles only in the first pass
			core_step <= (pass == '0) ? addr_t'(gat_cnt[3:2]) : '0;
		end
		// group index follows its operands through the core
		grp_pipe[0] <= grp_q;
		for (int i = 1; i < CORE_LATENCY; i++) begin
			grp_pipe[i] <= grp_pipe[i-1];
		end
	end

	dft_rdx4_core u_core (
		.clk (clk),
		.rst_n (rst_n),
		.in_valid (core_in_valid),
		.in_re0 (op_re[0]),
		.in_re1 (op_re[1]),
		.in_re2 (op_re[2]),
		.in_re3 (op_re[3]),
		.in_im0 (op_im[0]),
		.in_im1 (op_im[1]),
		.in_im2 (op_im[2]),
		.in_im3 (op_im[3]),
		.twdl_step (core_step),
		.out_valid (core_out_valid),
		.out_re0 (cr_re[0]),
		.out_re1 (cr_re[1]),
		.out_re2 (cr_re[2]),
		.out_re3 (cr_re[3]),
		.out_im0 (cr_im[0]),
		.out_im1 (cr_im[1]),
		.out_im2 (cr_im[2]),
		.out_im3 (cr_im[3])
	);

	// --------------------
	// write-back
	// --------------------
	// groups come every 4 cycles, so one group drains before the next lands
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wb_busy <= 1'b0;
			wb_k <= '0;
			wr_cnt <= '0;
			wr_en <= 1'b0;
			wr_done <= 1'b0;
		end else begin
			wr_en <= wb_busy;
			wr_done <= wb_busy && (wr_cnt == addr_t'(DFT_POINTS - 1));
			if (wb_busy) begin
				wr_cnt <= wr_cnt + 1'b1;
			end
			if (core_out_valid) begin
				wb_busy <= 1'b1;
				wb_k <= '0;
			end else if (wb_busy) begin
				wb_k <= wb_k + 1'b1;
				if (wb_k == 2'd3) begin
					wb_busy <= 1'b0;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (core_out_valid) begin
			for (int k = 0; k < RADIX; k++) begin
				wb_re[k] <= cr_re[k];
				wb_im[k] <= cr_im[k];
			end
			wb_grp <= grp_pipe[CORE_LATENCY-1];
		end
		wr_addr <= map_addr(pass, wb_grp, wb_k);
		wr_re <= wb_re[wb_k];
		wr_im <= wb_im[wb_k];
	end

endmodule

`default_nettype wire

/* src/dft_source.sv */
`timescale 1ns/1ps
`default_nettype none

module dft_source import dft_pkg::*; (
	input wire clk,
	input wire rst_n,
	input wire active,
	input wire out_credit,
	output logic rd_en,
	output addr_t rd_addr,
	input wire sample_t rd_re,
	input wire sample_t rd_im,
	output logic out_valid,
	output logic out_sop,
	output logic out_eop,
	output sample_t out_re,
	output sample_t out_im,
	output logic source_done
);

	localparam int CRED_W = $clog2(OUT_CREDITS + 1);

	logic [CRED_W-1:0] credit;
	// output index i
	addr_t rd_cnt;
	logic rd_fin;
	logic [1:0] rd_vld_d;
	addr_t out_cnt;

	// digit reversal, word 4*(i mod 4) + i/4
	assign rd_addr = {rd_cnt[1:0], rd_cnt[3:2]};
	// stall the read counter when out of credits
	assign rd_en = active && !rd_fin && (credit != '0);

	// --------------------
	// credits and reads
	// --------------------
	// a credit is taken at read issue, so every word in flight owns one
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			credit <= CRED_W'(OUT_CREDITS);
			rd_cnt <= '0;
			rd_fin <= 1'b0;
		end else begin
			credit <= credit - CRED_W'(rd_en) + CRED_W'(out_credit);
			if (rd_en) begin
				rd_cnt <= rd_cnt + 1'b1;
				if (rd_cnt == addr_t'(DFT_POINTS - 1)) begin
					rd_fin <= 1'b1;
				end
			end else if (!active) begin
				rd_fin <= 1'b0;
			end
		end
	end

	// --------------------
	// output
	// --------------------
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			rd_vld_d <= '0;
			out_cnt <= '0;
			out_valid <= 1'b0;
			out_sop <= 1'b0;
			out_eop <= 1'b0;
			source_done <= 1'b0;
		end else begin
			rd_vld_d <= {rd_vld_d[0], rd_en};
			out_valid <= rd_vld_d[1];
			out_sop <= rd_vld_d[1] && (out_cnt == '0);
			out_eop <= rd_vld_d[1] && (out_cnt == addr_t'(DFT_POINTS - 1));
			source_done <= rd_vld_d[1] && (out_cnt == addr_t'(DFT_POINTS - 1));
			if (rd_vld_d[1]) begin
				out_cnt <= out_cnt + 1'b1;
			end
		end
	end

	// one-entry hold, keeps the last word until the next arrives
	always_ff @(posedge clk) begin
		if (rd_vld_d[1]) begin
			out_re <= rd_re;
			out_im <= rd_im;
		end
	end

endmodule

`default_nettype wire

/* src/dft_sink.sv */
`timescale 1ns/1ps
`default_nettype none

module dft_sink import dft_pkg::*; (
	input wire clk,
	input wire rst_n,
	input wire active,
	input wire in_sop,
	input wire in_valid,
	input wire sample_t in_re,
	input wire sample_t in_im,
	output logic wr_en,
	output addr_t wr_addr,
	output sample_t wr_re,
	output sample_t wr_im,
	output logic sink_done
);

	// samples taken so far, doubles as the write address
	addr_t cnt;
	logic accept;

	// first sample needs sop, the rest only need valid
	// nothing is taken in the cycle that closes the frame
	assign accept = active && in_valid && !sink_done && (in_sop || cnt != '0);

	// --------------------
	// count and strobes
	// --------------------
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			cnt <= '0;
			wr_en <= 1'b0;
			sink_done <= 1'b0;
		end else begin
			wr_en <= accept;
			// pulse lines up with the last write
			sink_done <= accept && (cnt == addr_t'(DFT_POINTS - 1));
			if (accept) begin
				cnt <= cnt + 1'b1;
			end
		end
	end

	// natural order, sample i goes to word i
	always_ff @(posedge clk) begin
		wr_addr <= cnt;
		wr_re <= in_re;
		wr_im <= in_im;
	end

endmodule

`default_nettype wire

/* src/dft_rdx4_core.sv */
`timescale 1ns/1ps
`default_nettype none

module dft_rdx4_core import dft_pkg::*; (
	input wire clk,
	input wire rst_n,
	input wire in_valid,
	input wire sample_t in_re0,
	input wire sample_t in_re1,
	input wire sample_t in_re2,
	input wire sample_t in_re3,
	input wire sample_t in_im0,
	input wire sample_t in_im1,
	input wire sample_t in_im2,
	input wire sample_t in_im3,
	input wire addr_t twdl_step,
	output logic out_valid,
	output sample_t out_re0,
	output sample_t out_re1,
	output sample_t out_re2,
	output sample_t out_re3,
	output sample_t out_im0,
	output sample_t out_im1,
	output sample_t out_im2,
	output sample_t out_im3
);

	// room for a sum of four
	localparam int ACC_W = SAMPLE_W + 2;
	localparam int PROD_W = SAMPLE_W + TWDL_W;

	sample_t x_re [RADIX];
	sample_t x_im [RADIX];
	logic signed [ACC_W-1:0] bf_re [RADIX];
	logic signed [ACC_W-1:0] bf_im [RADIX];
	sample_t s1_re [RADIX];
	sample_t s1_im [RADIX];
	addr_t s1_step;
	sample_t s2_re [RADIX];
	sample_t s2_im [RADIX];
	twdl_t c_re [RADIX];
	twdl_t c_im [RADIX];
	logic signed [PROD_W-1:0] pr_re [RADIX];
	logic signed [PROD_W-1:0] pr_im [RADIX];
	sample_t y_re [RADIX];
	sample_t y_im [RADIX];
	logic [CORE_LATENCY-1:0] vld_sr;

	assign x_re[0] = in_re0;
	assign x_re[1] = in_re1;
	assign x_re[2] = in_re2;
	assign x_re[3] = in_re3;
	assign x_im[0] = in_im0;
	assign x_im[1] = in_im1;
	assign x_im[2] = in_im2;
	assign x_im[3] = in_im3;

	// --------------------
	// radix-4 butterfly
	// --------------------
	// y1 rotates by -j, y3 by +j
	always_comb begin
		bf_re[0] = x_re[0] + x_re[1] + x_re[2] + x_re[3];
		bf_im[0] = x_im[0] + x_im[1] + x_im[2] + x_im[3];
		bf_re[1] = x_re[0] + x_im[1] - x_re[2] - x_im[3];
		bf_im[1] = x_im[0] - x_re[1] - x_im[2] + x_re[3];
		bf_re[2] = x_re[0] - x_re[1] + x_re[2] - x_re[3];
		bf_im[2] = x_im[0] - x_im[1] + x_im[2] - x_im[3];
		bf_re[3] = x_re[0] - x_im[1] - x_re[2] + x_im[3];
		bf_im[3] = x_im[0] + x_re[1] - x_im[2] - x_re[3];
	end

	// complex multiply, coefficient sign already in c_im
	always_comb begin
		for (int k = 0; k < RADIX; k++) begin
			pr_re[k] = s2_re[k] * c_re[k] - s2_im[k] * c_im[k];
			pr_im[k] = s2_re[k] * c_im[k] + s2_im[k] * c_re[k];
		end
	end

	// --------------------
	// pipeline
	// --------------------
	always_ff @(posedge clk) begin
		for (int k = 0; k < RADIX; k++) begin
			// stage 1, fixed scale by 1/4
			s1_re[k] <= bf_re[k][ACC_W-1:2];
			s1_im[k] <= bf_im[k][ACC_W-1:2];
			// stage 2, W^(step*k), index wraps mod 16
			s2_re[k] <= s1_re[k];
			s2_im[k] <= s1_im[k];
			c_re[k] <= TWDL_COS[addr_t'(s1_step * addr_t'(k))];
			c_im[k] <= TWDL_SIN[addr_t'(s1_step * addr_t'(k))];
			// stage 3, drop the Q14 fraction, keep 16 bits
			y_re[k] <= pr_re[k][TWDL_FRAC +: SAMPLE_W];
			y_im[k] <= pr_im[k][TWDL_FRAC +: SAMPLE_W];
		end
		s1_step <= twdl_step;
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			vld_sr <= '0;
		end else begin
			vld_sr <= {vld_sr[CORE_LATENCY-2:0], in_valid};
		end
	end

	assign out_valid = vld_sr[CORE_LATENCY-1];
	assign out_re0 = y_re[0];
	assign out_re1 = y_re[1];
	assign out_re2 = y_re[2];
	assign out_re3 = y_re[3];
	assign out_im0 = y_im[0];
	assign out_im1 = y_im[1];
	assign out_im2 = y_im[2];
	assign out_im3 = y_im[3];

endmodule

`default_nettype wire

/* src/dft_pkg.sv */
`default_nettype none

package dft_pkg;

	// --------------------
	// widths
	// --------------------
	localparam int SAMPLE_W = 16;
	localparam int ADDR_W = 4;
	localparam int TWDL_W = 16;

	// --------------------
	// frame geometry
	// --------------------
	localparam int DFT_POINTS = 16;
	localparam int RADIX = 4;
	localparam int NUM_STAGES = 2;

	// twiddles are Q14, so 16384 is unity
	localparam int TWDL_FRAC = 14;
	// credits held by the output side after reset
	localparam int OUT_CREDITS = 4;
	// butterfly, twiddle lookup, multiply
	localparam int CORE_LATENCY = 3;

	// one real or imaginary part
	typedef logic signed [SAMPLE_W-1:0] sample_t;
	// one frame RAM word
	typedef logic [ADDR_W-1:0] addr_t;
	// twiddle coefficient
	typedef logic signed [TWDL_W-1:0] twdl_t;
	// pass index
	typedef logic [$clog2(NUM_STAGES)-1:0] stage_t;

	// frame FSM
	typedef enum logic [2:0] {
		IDLE,
		SINK,
		RD,
		WAIT_WR,
		SOURCE
	} frame_state_t;

	// --------------------
	// W16^k = cos - j sin
	// --------------------
	// real part, round(16384 * cos(2*pi*k/16))
	localparam twdl_t TWDL_COS [DFT_POINTS] = '{
		16'sd16384, 16'sd15137, 16'sd11585, 16'sd6270,
		16'sd0, -16'sd6270, -16'sd11585, -16'sd15137,
		-16'sd16384, -16'sd15137, -16'sd11585, -16'sd6270,
		16'sd0, 16'sd6270, 16'sd11585, 16'sd15137
	};

	// imaginary part, sign already folded in
	localparam twdl_t TWDL_SIN [DFT_POINTS] = '{
		16'sd0, -16'sd6270, -16'sd11585, -16'sd15137,
		-16'sd16384, -16'sd15137, -16'sd11585, -16'sd6270,
		16'sd0, 16'sd6270, 16'sd11585, 16'sd15137,
		16'sd16384, 16'sd15137, 16'sd11585, 16'sd6270
	};

endpackage

`default_nettype wire
